// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS = --binary --timing --assert --timescale 1ns/1ps
TOP = dispatch_tb
FILELIST = vlog.f
OBJ_DIR = obj_dir
PASS_STRING = === PASS ===

SIM = $(OBJ_DIR)/V$(TOP)
SOURCES = $(filter-out +%,$(shell cat $(FILELIST)))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q -F -x '$(PASS_STRING)'

clean:
	rm -rf $(OBJ_DIR)

// ==== logic/dispatch_pkg.sv ====
// Dispatch stage shared definitions

`default_nettype none

package dispatch_pkg;

	// ========================================================================
	// Sizes
	// ========================================================================

	// Default reorder buffer depth
	parameter int ROB_ENTRIES = 8;

	// Index into the reorder buffer
	typedef logic [2:0] rob_ndx_t;

	// Four functional units sit behind the dispatcher
	parameter int NUM_UNITS = 4;
	parameter int UNIT_ALU0 = 0;
	parameter int UNIT_ALU1 = 1;
	parameter int UNIT_MUL = 2;
	parameter int UNIT_MEM = 3;

	// Default reservation queue depth, which is also the starting credit count
	parameter int QUEUE_DEPTH = 2;

	// ========================================================================
	// Instruction encodings
	// ========================================================================

	// Operation class decides which unit can take the instruction
	typedef enum logic [1:0] {
		CLS_ALU = 2'd0,
		CLS_MUL = 2'd1,
		CLS_MEM = 2'd2
	} op_class_t;

	// The operand word is read either as three registers or as rd plus a
	// signed 11 bit immediate, chosen by the entry's format bit
	typedef union packed {
		struct packed {
			logic [4:0] rd;
			logic [4:0] rs1;
			logic [4:0] rs2;
			logic pad;
		} reg_f;
		struct packed {
			logic [4:0] rd;
			logic signed [10:0] imm;
		} imm_f;
	} operand_u;

	// One reorder buffer slot
	typedef struct packed {
		logic v;
		logic rdy;
		logic disp;
		logic done;
		op_class_t cls;
		// High selects the immediate view of opnd
		logic immf;
		operand_u opnd;
	} rob_entry_t;

	// Decoded entry as it is held in a reservation queue
	typedef struct packed {
		rob_ndx_t rndx;
		logic nop;
		logic [4:0] rd;
		logic [4:0] src1;
		logic [4:0] src2;
		logic [15:0] imm;
		logic immv;
	} rse_entry_t;

endpackage

`default_nettype wire

// ==== logic/dispatch_top.sv ====
// Dispatch stage top level

`default_nettype none

module dispatch_top
	import dispatch_pkg::*;
#(
	parameter int ROB_ENTRIES = dispatch_pkg::ROB_ENTRIES,
	parameter int QUEUE_DEPTH = dispatch_pkg::QUEUE_DEPTH
) (
	input wire logic clk,
	input wire logic rst,
	input wire logic alloc_valid_i,
	input op_class_t alloc_cls_i,
	input wire logic alloc_immf_i,
	input wire logic [15:0] alloc_opnd_i,
	input wire logic alloc_rdy_i,
	output rob_ndx_t alloc_ndx_o,
	output logic rob_full_o,
	input wire logic wake_valid_i,
	input rob_ndx_t wake_rob_i,
	input wire logic [ROB_ENTRIES-1:0] stomp_i,
	input wire logic complete_valid_i,
	input rob_ndx_t complete_rob_i,
	output logic [NUM_UNITS-1:0] issue_valid_o,
	input wire logic [NUM_UNITS-1:0] issue_ready_i,
	output rse_entry_t [NUM_UNITS-1:0] issue_entry_o,
	output logic retire_valid_o,
	output rob_ndx_t retire_rob_o
);

	// ROB to dispatcher link
	rob_entry_t [ROB_ENTRIES-1:0] rob_entries;
	logic [ROB_ENTRIES-1:0] dispatchable;
	logic [ROB_ENTRIES-1:0] mark;

	// One push and credit link per functional unit
	rse_if rse_link [NUM_UNITS] ();

	rob_file #(
		.ROB_ENTRIES(ROB_ENTRIES)
	) u_rob (
		.clk(clk),
		.rst(rst),
		.alloc_valid_i(alloc_valid_i),
		.alloc_cls_i(alloc_cls_i),
		.alloc_immf_i(alloc_immf_i),
		.alloc_opnd_i(alloc_opnd_i),
		.alloc_rdy_i(alloc_rdy_i),
		.alloc_ndx_o(alloc_ndx_o),
		.rob_full_o(rob_full_o),
		.wake_valid_i(wake_valid_i),
		.wake_rob_i(wake_rob_i),
		.complete_valid_i(complete_valid_i),
		.complete_rob_i(complete_rob_i),
		.mark_i(mark),
		.rob_o(rob_entries),
		.dispatchable_o(dispatchable),
		.retire_valid_o(retire_valid_o),
		.retire_rob_o(retire_rob_o)
	);

	instruction_dispatcher #(
		.ROB_ENTRIES(ROB_ENTRIES),
		.QUEUE_DEPTH(QUEUE_DEPTH)
	) u_dispatcher (
		.clk(clk),
		.rst(rst),
		.rob_i(rob_entries),
		.dispatchable_i(dispatchable),
		.stomp_i(stomp_i),
		.mark_o(mark),
		.rse(rse_link)
	);

	// Unit order here matches UNIT_ALU0 through UNIT_MEM
	for (genvar u = 0; u < NUM_UNITS; u++) begin : g_queue
		reservation_queue #(
			.QUEUE_DEPTH(QUEUE_DEPTH)
		) u_queue (
			.clk(clk),
			.rst(rst),
			.rse(rse_link[u]),
			.issue_valid_o(issue_valid_o[u]),
			.issue_ready_i(issue_ready_i[u]),
			.issue_entry_o(issue_entry_o[u])
		);
	end

endmodule

`default_nettype wire

// ==== logic/instruction_dispatcher.sv ====
// Instruction dispatcher

`default_nettype none

module instruction_dispatcher
	import dispatch_pkg::*;
#(
	parameter int ROB_ENTRIES = dispatch_pkg::ROB_ENTRIES,
	parameter int QUEUE_DEPTH = dispatch_pkg::QUEUE_DEPTH
) (
	input wire logic clk,
	input wire logic rst,
	input rob_entry_t [ROB_ENTRIES-1:0] rob_i,
	input wire logic [ROB_ENTRIES-1:0] dispatchable_i,
	input wire logic [ROB_ENTRIES-1:0] stomp_i,
	output logic [ROB_ENTRIES-1:0] mark_o,
	rse_if.disp rse [NUM_UNITS]
);

	// Credit counter has to hold the full queue depth
	localparam int CRD_W = $clog2(QUEUE_DEPTH + 1);

	logic [NUM_UNITS-1:0] credit_ok;
	logic [NUM_UNITS-1:0] sel_v;
	rob_ndx_t sel_ndx [NUM_UNITS];
	logic [ROB_ENTRIES-1:0] taken;

	// Class served by each unit; both ALU units take ALU work
	function automatic op_class_t unit_class(input int u);
		case (u)
			UNIT_ALU0: return CLS_ALU;
			UNIT_ALU1: return CLS_ALU;
			UNIT_MUL: return CLS_MUL;
			default: return CLS_MEM;
		endcase
	endfunction

	// Turn a ROB slot into a queue entry
	// Squashed slots still travel so the ROB can account for them
	function automatic rse_entry_t build_entry(
		input rob_entry_t e,
		input rob_ndx_t ndx,
		input logic stomped
	);
		rse_entry_t r;
		r = '0;
		r.rndx = ndx;
		if (stomped) begin
			r.nop = 1'b1;
		end else if (e.immf) begin
			r.rd = e.opnd.imm_f.rd;
			r.imm = {{5{e.opnd.imm_f.imm[10]}}, e.opnd.imm_f.imm};
			r.immv = 1'b1;
		end else begin
			r.rd = e.opnd.reg_f.rd;
			r.src1 = e.opnd.reg_f.rs1;
			r.src2 = e.opnd.reg_f.rs2;
		end
		return r;
	endfunction

	// ========================================================================
	// Selection
	// ========================================================================

	// Units are scanned in order so alu0 always gets the first ALU pick and
	// alu1 the next one; each unit takes the lowest free index of its class
	always_comb begin
		taken = '0;
		sel_v = '0;
		for (int u = 0; u < NUM_UNITS; u++) begin
			sel_ndx[u] = '0;
			for (int n = 0; n < ROB_ENTRIES; n++) begin
				if (!sel_v[u] && credit_ok[u] && dispatchable_i[n] && !taken[n] &&
					rob_i[n].cls == unit_class(u)) begin
					sel_v[u] = 1'b1;
					sel_ndx[u] = rob_ndx_t'(n);
					taken[n] = 1'b1;
				end
			end
		end
	end

	// ROB sets its dispatched flags on the edge that latches the sends
	assign mark_o = taken;

	// ========================================================================
	// Per unit credits and output registers
	// ========================================================================

	for (genvar u = 0; u < NUM_UNITS; u++) begin : g_unit
		logic [CRD_W-1:0] credit_q;
		logic send_q;
		rse_entry_t entry_q;

		assign credit_ok[u] = (credit_q != '0);

		// A send and a returned credit in the same cycle cancel out
		always_ff @(posedge clk) begin
			if (rst) begin
				credit_q <= CRD_W'(QUEUE_DEPTH);
				send_q <= 1'b0;
			end else begin
				credit_q <= credit_q + CRD_W'(rse[u].credit) - CRD_W'(sel_v[u]);
				send_q <= sel_v[u];
			end
		end

		always_ff @(posedge clk) begin
			if (sel_v[u]) begin
				entry_q <= build_entry(rob_i[sel_ndx[u]], sel_ndx[u], stomp_i[sel_ndx[u]]);
			end
		end

		assign rse[u].send = send_q;
		assign rse[u].entry = entry_q;

		// Returned credits never outnumber the queue slots, so a nonzero count
		// always stands for a free slot behind the link
		a_credit_range: assert property (@(posedge clk) disable iff (rst)
			credit_q <= CRD_W'(QUEUE_DEPTH));
	end

endmodule

`default_nettype wire

// ==== logic/reservation_queue.sv ====
// Reservation queue

`default_nettype none

module reservation_queue
	import dispatch_pkg::*;
#(
	parameter int QUEUE_DEPTH = dispatch_pkg::QUEUE_DEPTH
) (
	input wire logic clk,
	input wire logic rst,
	rse_if.queue rse,
	output logic issue_valid_o,
	input wire logic issue_ready_i,
	output rse_entry_t issue_entry_o
);

	// A depth of one still needs a pointer bit
	localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
	localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

	rse_entry_t mem_q [QUEUE_DEPTH];
	logic [PTR_W-1:0] rd_ptr_q;
	logic [PTR_W-1:0] wr_ptr_q;
	logic [CNT_W-1:0] count_q;
	logic credit_q;
	logic push;
	logic pop;
	logic full;

	function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign push = rse.send;
	assign pop = issue_valid_o && issue_ready_i;
	assign full = (count_q == CNT_W'(QUEUE_DEPTH));

	// Oldest entry is offered to the unit
	assign issue_valid_o = (count_q != '0);
	assign issue_entry_o = mem_q[rd_ptr_q];

	always_ff @(posedge clk) begin
		if (rst) begin
			rd_ptr_q <= '0;
			wr_ptr_q <= '0;
			count_q <= '0;
			credit_q <= 1'b0;
		end else begin
			if (push) begin
				wr_ptr_q <= ptr_next(wr_ptr_q);
			end
			if (pop) begin
				rd_ptr_q <= ptr_next(rd_ptr_q);
			end
			count_q <= count_q + CNT_W'(push) - CNT_W'(pop);
			// Freed slot goes back to the dispatcher a cycle later
			credit_q <= pop;
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			mem_q[wr_ptr_q] <= rse.entry;
		end
	end

	assign rse.credit = credit_q;

	// Credit accounting in the dispatcher keeps pushes off a full queue
	a_no_push_full: assert property (@(posedge clk) disable iff (rst)
		push |-> !full);

endmodule

`default_nettype wire

// ==== logic/rob_file.sv ====
// Reorder buffer storage

`default_nettype none

module rob_file
	import dispatch_pkg::*;
#(
	parameter int ROB_ENTRIES = dispatch_pkg::ROB_ENTRIES
) (
	input wire logic clk,
	input wire logic rst,
	input wire logic alloc_valid_i,
	input op_class_t alloc_cls_i,
	input wire logic alloc_immf_i,
	input wire logic [15:0] alloc_opnd_i,
	input wire logic alloc_rdy_i,
	output rob_ndx_t alloc_ndx_o,
	output logic rob_full_o,
	input wire logic wake_valid_i,
	input rob_ndx_t wake_rob_i,
	input wire logic complete_valid_i,
	input rob_ndx_t complete_rob_i,
	input wire logic [ROB_ENTRIES-1:0] mark_i,
	output rob_entry_t [ROB_ENTRIES-1:0] rob_o,
	output logic [ROB_ENTRIES-1:0] dispatchable_o,
	output logic retire_valid_o,
	output rob_ndx_t retire_rob_o
);

	// Occupancy counter has to reach ROB_ENTRIES itself
	localparam int CNT_W = $clog2(ROB_ENTRIES + 1);

	rob_entry_t [ROB_ENTRIES-1:0] rob_q;
	rob_ndx_t head_q;
	rob_ndx_t tail_q;
	logic [CNT_W-1:0] count_q;
	logic alloc_take;
	logic retire;

	// Circular increment that also works for depths that are not a power of two
	function automatic rob_ndx_t rob_next(input rob_ndx_t p);
		return (p == rob_ndx_t'(ROB_ENTRIES - 1)) ? '0 : p + 1'b1;
	endfunction

	assign rob_full_o = (count_q == CNT_W'(ROB_ENTRIES));
	assign alloc_ndx_o = tail_q;
	assign alloc_take = alloc_valid_i && !rob_full_o;

	// The oldest entry leaves once its completion has been seen
	assign retire = rob_q[head_q].v && rob_q[head_q].done;
	assign retire_valid_o = retire;
	assign retire_rob_o = head_q;

	// Dispatcher sees every slot and a ready-to-go summary
	assign rob_o = rob_q;

	always_comb begin
		for (int n = 0; n < ROB_ENTRIES; n++) begin
			dispatchable_o[n] = rob_q[n].v && rob_q[n].rdy && !rob_q[n].disp;
		end
	end

	// ========================================================================
	// Slot state
	// ========================================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int n = 0; n < ROB_ENTRIES; n++) begin
				rob_q[n].v <= 1'b0;
				rob_q[n].rdy <= 1'b0;
				rob_q[n].disp <= 1'b0;
				rob_q[n].done <= 1'b0;
			end
			head_q <= '0;
			tail_q <= '0;
			count_q <= '0;
		end else begin
			for (int n = 0; n < ROB_ENTRIES; n++) begin
				// A wakeup only matters for a live slot
				if (wake_valid_i && wake_rob_i == rob_ndx_t'(n) && rob_q[n].v) begin
					rob_q[n].rdy <= 1'b1;
				end
				// Marked on the same edge the dispatcher latches the entry
				if (mark_i[n]) begin
					rob_q[n].disp <= 1'b1;
				end
				if (complete_valid_i && complete_rob_i == rob_ndx_t'(n)) begin
					rob_q[n].done <= 1'b1;
				end
			end
			if (retire) begin
				rob_q[head_q].v <= 1'b0;
				head_q <= rob_next(head_q);
			end
			// Allocation comes last so a stale pulse aimed at the tail loses
			if (alloc_take) begin
				rob_q[tail_q] <= '{
					v: 1'b1,
					rdy: alloc_rdy_i,
					disp: 1'b0,
					done: 1'b0,
					cls: alloc_cls_i,
					immf: alloc_immf_i,
					opnd: operand_u'(alloc_opnd_i)
				};
				tail_q <= rob_next(tail_q);
			end
			count_q <= count_q + CNT_W'(alloc_take) - CNT_W'(retire);
		end
	end

	// ========================================================================
	// Checks
	// ========================================================================

	// Execution can only report on something the dispatcher already sent out
	a_complete_live: assert property (@(posedge clk) disable iff (rst)
		complete_valid_i |-> rob_q[complete_rob_i].v && rob_q[complete_rob_i].disp);

	// The front end must hold off while every slot is taken
	a_no_alloc_full: assert property (@(posedge clk) disable iff (rst)
		alloc_valid_i |-> !rob_full_o);

endmodule

`default_nettype wire

// ==== logic/rse_if.sv ====
// Reservation queue link

`default_nettype none

interface rse_if
	import dispatch_pkg::*;
();

	// One cycle push from the dispatcher into the queue
	logic send;

	// Decoded entry, only meaningful while send is high
	rse_entry_t entry;

	// One cycle pulse from the queue for every entry that left it
	logic credit;

	// Dispatcher side drives the push and watches returned credits
	modport disp (
		output send,
		output entry,
		input credit
	);

	// Queue side accepts the push and returns credits
	modport queue (
		input send,
		input entry,
		output credit
	);

endinterface

`default_nettype wire

// ==== verification/dispatch_tb.sv ====
// Dispatch stage testbench

`default_nettype none

module dispatch_tb
	import dispatch_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	// Longest any single wait loop may spin, in clock cycles
	localparam int TIMEOUT = 200;

	logic clk;
	logic rst;
	logic alloc_valid;
	op_class_t alloc_cls;
	logic alloc_immf;
	logic [15:0] alloc_opnd;
	logic alloc_rdy;
	rob_ndx_t alloc_ndx;
	logic rob_full;
	logic wake_valid;
	rob_ndx_t wake_rob;
	logic [ROB_ENTRIES-1:0] stomp;
	logic complete_valid;
	rob_ndx_t complete_rob;
	logic [NUM_UNITS-1:0] issue_valid;
	logic [NUM_UNITS-1:0] issue_ready;
	rse_entry_t [NUM_UNITS-1:0] issue_entry;
	logic retire_valid;
	rob_ndx_t retire_rob;

	// Reference copy of what was written into each ROB slot
	logic m_immf [ROB_ENTRIES];
	logic [15:0] m_opnd [ROB_ENTRIES];
	logic m_stomp [ROB_ENTRIES];
	rob_ndx_t m_tail;
	// Allocated entries not yet retired, oldest first
	rob_ndx_t rob_order [$];

	// Every entry that left a queue, in the order it left
	int issued_unit [$];
	rse_entry_t issued_entry [$];
	int issued_cyc [$];
	int cycle;
	int retired;
	int mismatches;
	int failures;

	dispatch_top #(
		.ROB_ENTRIES(ROB_ENTRIES),
		.QUEUE_DEPTH(QUEUE_DEPTH)
	) u_dut (
		.clk(clk),
		.rst(rst),
		.alloc_valid_i(alloc_valid),
		.alloc_cls_i(alloc_cls),
		.alloc_immf_i(alloc_immf),
		.alloc_opnd_i(alloc_opnd),
		.alloc_rdy_i(alloc_rdy),
		.alloc_ndx_o(alloc_ndx),
		.rob_full_o(rob_full),
		.wake_valid_i(wake_valid),
		.wake_rob_i(wake_rob),
		.stomp_i(stomp),
		.complete_valid_i(complete_valid),
		.complete_rob_i(complete_rob),
		.issue_valid_o(issue_valid),
		.issue_ready_i(issue_ready),
		.issue_entry_o(issue_entry),
		.retire_valid_o(retire_valid),
		.retire_rob_o(retire_rob)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#2 clk = ~clk;
		end
	end

	// ========================================================================
	// Monitor
	// ========================================================================

	// Sampled on the edge itself, so these are the values of the cycle that ends
	always @(posedge clk) begin : monitor
		rob_ndx_t want_r;
		if (!rst) begin
			for (int u = 0; u < NUM_UNITS; u++) begin
				if (issue_valid[u] && issue_ready[u]) begin
					issued_unit.push_back(u);
					issued_entry.push_back(issue_entry[u]);
					issued_cyc.push_back(cycle);
				end
			end
			if (retire_valid) begin
				retired++;
				if (rob_order.size() == 0) begin
					failures++;
					$display("ROB entry %0d retired at %0t with nothing outstanding",
						retire_rob, $time);
				end else begin
					want_r = rob_order.pop_front();
					if (retire_rob !== want_r) begin
						mismatches++;
						$display("mismatch at %0t: retired entry %0d, expected %0d",
							$time, retire_rob, want_r);
					end
				end
			end
			cycle++;
		end
	end

	// ========================================================================
	// Helpers
	// ========================================================================

	// Inputs change 1 ns after the rising edge
	task automatic step();
		@(posedge clk);
		#1;
	endtask

	function automatic logic [15:0] rand_opnd();
		logic [31:0] r;
		r = $urandom();
		return r[15:0];
	endfunction

	// Decoded form of a slot where rd always sits in the top five bits of the word
	function automatic rse_entry_t expected_entry(input rob_ndx_t ndx);
		rse_entry_t e;
		logic [15:0] w;
		e = '0;
		w = m_opnd[ndx];
		e.rndx = ndx;
		if (m_stomp[ndx]) begin
			e.nop = 1'b1;
		end else if (m_immf[ndx]) begin
			e.rd = w[15:11];
			e.imm = {{5{w[10]}}, w[10:0]};
			e.immv = 1'b1;
		end else begin
			e.rd = w[15:11];
			e.src1 = w[10:6];
			e.src2 = w[5:1];
		end
		return e;
	endfunction

	task automatic alloc(input op_class_t cls, input logic immf, input logic rdy,
		input logic [15:0] opnd, output rob_ndx_t ndx);
		ndx = alloc_ndx;
		if (rob_full) begin
			failures++;
			$display("allocation at %0t was refused because the ROB is full", $time);
			return;
		end
		if (alloc_ndx !== m_tail) begin
			mismatches++;
			$display("mismatch at %0t: alloc index %0d, expected %0d", $time, alloc_ndx, m_tail);
		end
		alloc_valid = 1'b1;
		alloc_cls = cls;
		alloc_immf = immf;
		alloc_opnd = opnd;
		alloc_rdy = rdy;
		m_immf[ndx] = immf;
		m_opnd[ndx] = opnd;
		m_stomp[ndx] = stomp[ndx];
		rob_order.push_back(ndx);
		m_tail = (m_tail == rob_ndx_t'(ROB_ENTRIES - 1)) ? '0 : m_tail + 1'b1;
		step();
		alloc_valid = 1'b0;
	endtask

	task automatic wake(input rob_ndx_t ndx);
		wake_valid = 1'b1;
		wake_rob = ndx;
		step();
		wake_valid = 1'b0;
	endtask

	task automatic complete_entry(input rob_ndx_t ndx);
		complete_valid = 1'b1;
		complete_rob = ndx;
		step();
		complete_valid = 1'b0;
	endtask

	task automatic clear_issued();
		issued_unit.delete();
		issued_entry.delete();
		issued_cyc.delete();
	endtask

	task automatic wait_issues(input int n);
		int t;
		t = 0;
		while (issued_entry.size() < n && t < TIMEOUT) begin
			step();
			t++;
		end
		if (issued_entry.size() < n) begin
			failures++;
			$display("timed out at %0t waiting for %0d issued entries, saw %0d",
				$time, n, issued_entry.size());
		end
	endtask

	task automatic check_issue(input int k, input int unit, input rob_ndx_t ndx);
		rse_entry_t want;
		if (k >= issued_entry.size()) begin
			return;
		end
		want = expected_entry(ndx);
		if (issued_unit[k] != unit) begin
			mismatches++;
			$display("mismatch at %0t: entry %0d left unit %0d, expected unit %0d",
				$time, ndx, issued_unit[k], unit);
		end
		if (issued_entry[k] !== want) begin
			mismatches++;
			$display("mismatch at %0t: unit %0d issued %h, expected %h",
				$time, unit, issued_entry[k], want);
		end
	endtask

	// Complete every outstanding entry oldest first and let the ROB empty
	task automatic retire_all();
		rob_ndx_t pend [$];
		int t;
		pend = rob_order;
		foreach (pend[k]) begin
			complete_entry(pend[k]);
		end
		t = 0;
		while (rob_order.size() != 0 && t < TIMEOUT) begin
			step();
			t++;
		end
		if (rob_order.size() != 0) begin
			failures++;
			$display("timed out at %0t with %0d entries never retired", $time, rob_order.size());
		end
	endtask

	// ========================================================================
	// Tests
	// ========================================================================

	task automatic test_reset_alu();
		rob_ndx_t a;
		int t0;
		if (issue_valid !== '0 || retire_valid !== 1'b0 || rob_full !== 1'b0) begin
			mismatches++;
			$display("mismatch at %0t: outputs are not idle after reset", $time);
		end
		clear_issued();
		alloc(CLS_ALU, 1'b0, 1'b1, rand_opnd(), a);
		t0 = cycle;
		wait_issues(1);
		check_issue(0, UNIT_ALU0, a);
		// Dispatch one edge after allocation, visible after the next, popped on the third
		if (issued_cyc.size() > 0 && issued_cyc[0] != t0 + 2) begin
			mismatches++;
			$display("mismatch at %0t: issue latency off by %0d cycles", $time,
				issued_cyc[0] - t0 - 2);
		end
		retire_all();
	endtask

	task automatic test_routing();
		rob_ndx_t a;
		rob_ndx_t b;
		rob_ndx_t m;
		rob_ndx_t x;
		clear_issued();
		// A wakes on the edge that writes B, so both become eligible together
		alloc(CLS_ALU, 1'b0, 1'b0, rand_opnd(), a);
		wake_valid = 1'b1;
		wake_rob = a;
		alloc(CLS_ALU, 1'b0, 1'b1, rand_opnd(), b);
		wake_valid = 1'b0;
		alloc(CLS_MUL, 1'b0, 1'b1, rand_opnd(), m);
		// Bit 10 set forces a negative immediate
		alloc(CLS_MEM, 1'b1, 1'b1, rand_opnd() | 16'h0400, x);
		wait_issues(4);
		check_issue(0, UNIT_ALU0, (a < b) ? a : b);
		check_issue(1, UNIT_ALU1, (a < b) ? b : a);
		check_issue(2, UNIT_MUL, m);
		check_issue(3, UNIT_MEM, x);
		if (issued_cyc.size() >= 2 && issued_cyc[0] != issued_cyc[1]) begin
			mismatches++;
			$display("mismatch at %0t: the two ALU entries left in different cycles", $time);
		end
		retire_all();
	endtask

	task automatic test_wakeup();
		rob_ndx_t a;
		clear_issued();
		alloc(CLS_MUL, 1'b0, 1'b0, rand_opnd(), a);
		repeat (8) step();
		if (issued_entry.size() != 0) begin
			failures++;
			$display("entry %0d issued at %0t before its wakeup", a, $time);
		end
		wake(a);
		wait_issues(1);
		check_issue(0, UNIT_MUL, a);
		retire_all();
	endtask

	task automatic test_backpressure();
		rob_ndx_t n [4];
		rob_ndx_t late [$];
		int waiting;
		clear_issued();
		issue_ready[UNIT_MUL] = 1'b0;
		for (int k = 0; k < 4; k++) begin
			alloc(CLS_MUL, 1'b0, 1'b1, rand_opnd(), n[k]);
		end
		repeat (10) step();
		// The held queue keeps offering its oldest entry
		if (issue_valid[UNIT_MUL] !== 1'b1) begin
			mismatches++;
			$display("mismatch at %0t: mul queue offers nothing while held", $time);
		end
		// Only as many entries as there are credits may leave the ROB
		waiting = 0;
		for (int k = 0; k < 4; k++) begin
			if (u_dut.dispatchable[n[k]]) begin
				waiting++;
			end
		end
		if (waiting != 4 - QUEUE_DEPTH) begin
			mismatches++;
			$display("mismatch at %0t: %0d mul entries held in the ROB, expected %0d",
				$time, waiting, 4 - QUEUE_DEPTH);
		end
		issue_ready[UNIT_MUL] = 1'b1;
		wait_issues(4);
		repeat (6) step();
		if (issued_entry.size() != 4) begin
			mismatches++;
			$display("mismatch at %0t: %0d mul issues, expected 4", $time, issued_entry.size());
		end
		// Early ones went out as they arrived, the held ones lowest index first
		for (int k = QUEUE_DEPTH; k < 4; k++) begin
			late.push_back(n[k]);
		end
		late.sort();
		for (int k = 0; k < 4; k++) begin
			check_issue(k, UNIT_MUL, (k < QUEUE_DEPTH) ? n[k] : late[k - QUEUE_DEPTH]);
		end
		retire_all();
	endtask

	task automatic test_stomp();
		rob_ndx_t a;
		clear_issued();
		stomp[alloc_ndx] = 1'b1;
		alloc(CLS_MEM, 1'b1, 1'b1, rand_opnd(), a);
		wait_issues(1);
		stomp = '0;
		check_issue(0, UNIT_MEM, a);
		retire_all();
	endtask

	task automatic test_retire_order();
		rob_ndx_t n [ROB_ENTRIES];
		int r0;
		int t;
		clear_issued();
		for (int k = 0; k < ROB_ENTRIES; k++) begin
			alloc((k % 3 == 0) ? CLS_ALU : ((k % 3 == 1) ? CLS_MUL : CLS_MEM),
				k[0], 1'b1, rand_opnd(), n[k]);
		end
		if (rob_full !== 1'b1) begin
			mismatches++;
			$display("mismatch at %0t: ROB not full after %0d allocations", $time, ROB_ENTRIES);
		end
		wait_issues(ROB_ENTRIES);
		// Youngest first, so nothing may leave until the head is done
		r0 = retired;
		for (int k = ROB_ENTRIES - 1; k >= 1; k--) begin
			complete_entry(n[k]);
		end
		if (retired != r0 || rob_full !== 1'b1) begin
			failures++;
			$display("entries retired at %0t before the oldest one completed", $time);
		end
		complete_entry(n[0]);
		t = 0;
		while (rob_full && t < TIMEOUT) begin
			step();
			t++;
		end
		if (rob_full) begin
			failures++;
			$display("timed out at %0t waiting for the ROB to leave full", $time);
		end else if (retired == r0) begin
			failures++;
			$display("ROB left full at %0t without any retirement", $time);
		end
		retire_all();
	endtask

	// ========================================================================
	// Main sequence
	// ========================================================================

	initial begin
		void'($urandom(32'h183361ab));
		rst = 1'b1;
		alloc_valid = 1'b0;
		alloc_cls = CLS_ALU;
		alloc_immf = 1'b0;
		alloc_opnd = '0;
		alloc_rdy = 1'b0;
		wake_valid = 1'b0;
		wake_rob = '0;
		stomp = '0;
		complete_valid = 1'b0;
		complete_rob = '0;
		issue_ready = '1;
		m_tail = '0;
		cycle = 0;
		retired = 0;
		mismatches = 0;
		failures = 0;
		for (int k = 0; k < ROB_ENTRIES; k++) begin
			m_stomp[k] = 1'b0;
		end
		repeat (10) @(posedge clk);
		#1;
		rst = 1'b0;
		test_reset_alu();
		test_routing();
		test_wakeup();
		test_backpressure();
		test_stomp();
		test_retire_order();
		repeat (4) step();
		$display("errors: %0d mismatches, %0d other failures", mismatches, failures);
		if (mismatches == 0 && failures == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
logic/dispatch_pkg.sv
logic/rse_if.sv
logic/rob_file.sv
logic/instruction_dispatcher.sv
logic/reservation_queue.sv
logic/dispatch_top.sv
verification/dispatch_tb.sv
